/* Bender.yml */
package:
  name: eqv_verify

sources:
  - verilog/eqv_algo_pkg.sv
  - verilog/eqv_bus_pkg.sv
  - verilog/eqv_wb_regs.sv
  - verilog/eqv_index_unpack.sv
  - verilog/eqv_index_hash.sv
  - verilog/eqv_xor_check.sv
  - verilog/eqv_index_rules.sv
  - verilog/eqv_top.sv
  - target: test
    files:
      - tb/eqv_clk_gen.sv
      - tb/eqv_tb.sv

/* filelist.f */
verilog/eqv_algo_pkg.sv
verilog/eqv_bus_pkg.sv
verilog/eqv_wb_regs.sv
verilog/eqv_index_unpack.sv
verilog/eqv_index_hash.sv
verilog/eqv_xor_check.sv
verilog/eqv_index_rules.sv
verilog/eqv_top.sv
tb/eqv_clk_gen.sv
tb/eqv_tb.sv

/* tb/eqv_clk_gen.sv */
module eqv_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

endmodule

/* tb/eqv_tb.sv */
module eqv_tb;
  import eqv_algo_pkg::*;
  import eqv_bus_pkg::*;

  localparam int HASH_ROUNDS = 4;
  // Room for 20 runs that each take the pipeline latency plus about 40 bus cycles
  localparam int RUN_BUDGET = 20;
  localparam int TIMEOUT_CYCLES = 2 * RUN_BUDGET * (EQV_SOL_LEN + HASH_ROUNDS + 2 + 40);

  logic                    clk;
  logic                    rst;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [EQV_WB_AW-1:0]    wb_adr;
  logic [EQV_WB_DW-1:0]    wb_dat_w;
  logic [EQV_WB_DW-1:0]    wb_dat_r;
  logic                    wb_ack;
  int unsigned             cycle_cnt;
  eqv_seed_t               seed_a;
  logic [EQV_SOL_BITS-1:0] sol_a;
  logic [EQV_SOL_BITS-1:0] sol_b;
  eqv_mask_t               mask;
  eqv_mask_t               exp_mask;
  logic                    done;
  logic                    busy;

  eqv_clk_gen #(.PERIOD(20)) u_clk (.o_clk(clk));

  eqv_top #(.HASH_ROUNDS(HASH_ROUNDS)) UUT (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_dat_w),
    .o_wb_dat (wb_dat_r),
    .o_wb_ack (wb_ack)
  );

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $fatal(1, "Simulation stopped by the watchdog");
    end
  end

  task automatic check_mask(input eqv_mask_t got, input eqv_mask_t exp, input string what);
    if (got !== exp) begin
      $display("** Error @ %0t: %s mask is %b, expected %b", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "Mask mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "Flag mismatch");
    end
  endtask

  // Classic cycle that holds the request until ack is seen on a falling edge
  task automatic bus_write(input logic [EQV_WB_AW-1:0] adr, input logic [EQV_WB_DW-1:0] dat);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [EQV_WB_AW-1:0] adr, output logic [EQV_WB_DW-1:0] dat);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    dat    = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic read_status(output logic st_done, output logic st_busy, output eqv_mask_t m);
    logic [EQV_WB_DW-1:0] word;
    bus_read(STATUS, word);
    st_done = word[STAT_DONE];
    st_busy = word[STAT_BUSY];
    m       = word[STAT_MASK_LSB +: 4];
  endtask

  task automatic write_sol_words(input logic [EQV_SOL_BITS-1:0] sol);
    logic [4*EQV_WB_DW-1:0] wide;
    wide = (4 * EQV_WB_DW)'(sol);
    for (int w = 0; w < 4; w++) begin
      bus_write(EQV_WB_AW'(int'(SOL0) + w), wide[w*EQV_WB_DW +: EQV_WB_DW]);
    end
  endtask

  task automatic load_job(input eqv_seed_t seed, input logic [EQV_SOL_BITS-1:0] sol);
    bus_write(SEED_LO, seed[31:0]);
    bus_write(SEED_HI, seed[63:32]);
    write_sol_words(sol);
  endtask

  task automatic wait_done(output eqv_mask_t m);
    logic st_done;
    logic st_busy;
    st_done = 1'b0;
    while (!st_done) read_status(st_done, st_busy, m);
    check_flag(st_busy, 1'b0, "busy with done set");
  endtask

  // Reference mixer adds the seed, rotates left by 13 and xors the round number into the low byte
  function automatic eqv_str_t mix_string(input eqv_seed_t seed, input eqv_idx_t idx);
    logic [63:0] w;
    w = {51'b0, idx};
    for (int r = 0; r < HASH_ROUNDS; r++) begin
      w = w + seed;
      w = (w << 13) | (w >> 51);
      w[7:0] = w[7:0] ^ 8'(r);
    end
    return w[63 -: EQV_N];
  endfunction

  function automatic eqv_mask_t predict_mask(input eqv_seed_t seed,
                                             input logic [EQV_SOL_BITS-1:0] sol);
    eqv_idx_t  ids [EQV_SOL_LEN];
    eqv_str_t  strs [EQV_SOL_LEN];
    eqv_str_t  x;
    eqv_str_t  total;
    eqv_mask_t m;
    int        left;
    m     = '0;
    total = '0;
    for (int i = 0; i < EQV_SOL_LEN; i++) begin
      ids[i]  = sol[i*EQV_IDX_BITS +: EQV_IDX_BITS];
      strs[i] = mix_string(seed, ids[i]);
      total   = total ^ strs[i];
    end
    m[XOR_NON_ZERO] = (total != '0);
    for (int h = 1; h <= EQV_K; h++) begin
      for (int b = 0; b < (EQV_SOL_LEN >> h); b++) begin
        left = b << h;
        x = '0;
        for (int i = 0; i < (1 << h); i++) begin
          x = x ^ strs[left + i];
        end
        if ((x >> (EQV_N - h * EQV_COLL_BITS)) != '0) begin
          m[BAD_ZERO_ORDER] = 1'b1;
        end
        if (ids[left] >= ids[left + (1 << (h - 1))]) begin
          m[BAD_IDX_ORDER] = 1'b1;
        end
      end
    end
    for (int i = 0; i < EQV_SOL_LEN; i++) begin
      for (int j = i + 1; j < EQV_SOL_LEN; j++) begin
        if (ids[i] == ids[j]) begin
          m[DUPLICATE_FND] = 1'b1;
        end
      end
    end
    return m;
  endfunction

  function automatic logic [EQV_SOL_BITS-1:0] random_sol();
    logic [EQV_SOL_BITS-1:0] s;
    for (int i = 0; i < EQV_SOL_LEN; i++) begin
      s[i*EQV_IDX_BITS +: EQV_IDX_BITS] = eqv_idx_t'($urandom);
    end
    return s;
  endfunction

  // Strictly increasing indices whose largest value stays below 8000
  function automatic logic [EQV_SOL_BITS-1:0] sorted_sol();
    logic [EQV_SOL_BITS-1:0] s;
    int unsigned v;
    v = $urandom % 1000;
    for (int i = 0; i < EQV_SOL_LEN; i++) begin
      s[i*EQV_IDX_BITS +: EQV_IDX_BITS] = eqv_idx_t'(v);
      v = v + 1 + ($urandom % 1000);
    end
    return s;
  endfunction

  function automatic logic [EQV_SOL_BITS-1:0] paired_sol();
    logic [EQV_SOL_BITS-1:0] s;
    eqv_idx_t a;
    for (int p = 0; p < EQV_SOL_LEN / 2; p++) begin
      a = eqv_idx_t'($urandom);
      s[(2*p)*EQV_IDX_BITS +: EQV_IDX_BITS]   = a;
      s[(2*p+1)*EQV_IDX_BITS +: EQV_IDX_BITS] = a;
    end
    return s;
  endfunction

  task automatic run_case(input eqv_seed_t seed, input logic [EQV_SOL_BITS-1:0] sol,
                          input string what, output eqv_mask_t m);
    load_job(seed, sol);
    bus_write(CTRL, 32'd1);
    wait_done(m);
    check_mask(m, predict_mask(seed, sol), what);
  endtask

  initial begin
    void'($urandom(40));
    cycle_cnt = 0;
    rst       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    read_status(done, busy, mask);
    check_flag(done, 1'b0, "done after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_mask(mask, 4'b0000, "reset");

    for (int n = 0; n < 12; n++) begin
      run_case({$urandom, $urandom}, random_sol(), "random run", mask);
    end

    // Equal neighbours cancel at every level but break order and uniqueness
    run_case({$urandom, $urandom}, paired_sol(), "paired run", mask);
    check_flag(mask[XOR_NON_ZERO], 1'b0, "paired XOR_NON_ZERO");
    check_flag(mask[BAD_ZERO_ORDER], 1'b0, "paired BAD_ZERO_ORDER");
    check_flag(mask[BAD_IDX_ORDER], 1'b1, "paired BAD_IDX_ORDER");
    check_flag(mask[DUPLICATE_FND], 1'b1, "paired DUPLICATE_FND");

    seed_a = {$urandom, $urandom};
    sol_a  = sorted_sol();
    run_case(seed_a, sol_a, "sorted run", mask);
    check_flag(mask[BAD_IDX_ORDER], 1'b0, "sorted BAD_IDX_ORDER");
    check_flag(mask[DUPLICATE_FND], 1'b0, "sorted DUPLICATE_FND");
    sol_b = sol_a;
    sol_b[0 +: EQV_IDX_BITS]            = sol_a[EQV_IDX_BITS +: EQV_IDX_BITS];
    sol_b[EQV_IDX_BITS +: EQV_IDX_BITS] = sol_a[0 +: EQV_IDX_BITS];
    run_case(seed_a, sol_b, "swapped run", mask);
    check_flag(mask[BAD_IDX_ORDER], 1'b1, "swapped BAD_IDX_ORDER");
    check_flag(mask[DUPLICATE_FND], 1'b0, "swapped DUPLICATE_FND");

    // A second START with new words in place must not launch another run
    seed_a   = {$urandom, $urandom};
    sol_a    = random_sol();
    exp_mask = predict_mask(seed_a, sol_a);
    load_job(seed_a, sol_a);
    bus_write(CTRL, 32'd1);
    write_sol_words(paired_sol());
    bus_write(CTRL, 32'd1);
    wait_done(mask);
    check_mask(mask, exp_mask, "start while busy");
    repeat (10) begin
      read_status(done, busy, mask);
      check_flag(busy, 1'b0, "busy after ignored start");
      check_flag(done, 1'b1, "done after ignored start");
      check_mask(mask, exp_mask, "after ignored start");
    end

    // All ones in SOL0 would give the sorted set two equal leading indices
    seed_a   = {$urandom, $urandom};
    sol_a    = sorted_sol();
    exp_mask = predict_mask(seed_a, sol_a);
    load_job(seed_a, sol_a);
    bus_write(CTRL, 32'd1);
    bus_write(SOL0, 32'hFFFF_FFFF);
    wait_done(mask);
    check_mask(mask, exp_mask, "SOL0 rewritten during run");

    $display("No errors");
    $finish;
  end

endmodule

/* verilog/eqv_algo_pkg.sv */
package eqv_algo_pkg;

  // Test-scale Equihash, N = 48 and K = 3
  localparam int EQV_N = 48;
  localparam int EQV_K = 3;

  // Each level of the tree clears one collision slice of the string
  localparam int EQV_COLL_BITS = EQV_N / (EQV_K + 1);

  // An index selects one of 2**(collision bits + 1) strings
  localparam int EQV_IDX_BITS = EQV_COLL_BITS + 1;
  localparam int EQV_SOL_LEN  = 1 << EQV_K;
  localparam int EQV_SOL_BITS = EQV_SOL_LEN * EQV_IDX_BITS;

  typedef logic [EQV_IDX_BITS-1:0] eqv_idx_t;
  typedef logic [EQV_N-1:0]        eqv_str_t;
  typedef logic [63:0]             eqv_seed_t;

  // Stage state shared by the index unpacker and the bus slave
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } eqv_run_e;

endpackage

/* verilog/eqv_bus_pkg.sv */
package eqv_bus_pkg;

  localparam int EQV_WB_DW = 32;
  localparam int EQV_WB_AW = 3;

  // Word addresses of the host registers
  typedef enum logic [EQV_WB_AW-1:0] {
    SEED_LO = 3'd0,
    SEED_HI = 3'd1,
    SOL0    = 3'd2,
    SOL1    = 3'd3,
    SOL2    = 3'd4,
    SOL3    = 3'd5,
    CTRL    = 3'd6,
    STATUS  = 3'd7
  } eqv_reg_e;

  typedef logic [3:0] eqv_mask_t;

  // Flag positions inside eqv_mask_t
  localparam int XOR_NON_ZERO   = 0;
  localparam int BAD_ZERO_ORDER = 1;
  localparam int BAD_IDX_ORDER  = 2;
  localparam int DUPLICATE_FND  = 3;

  // Bit positions in the STATUS word
  localparam int STAT_DONE     = 0;
  localparam int STAT_BUSY     = 1;
  localparam int STAT_MASK_LSB = 4;

endpackage

/* verilog/eqv_index_hash.sv */
module eqv_index_hash #(
  parameter int HASH_ROUNDS = 4
) (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_start,
  input  eqv_algo_pkg::eqv_seed_t i_seed,
  input  logic                    i_val,
  input  logic                    i_last,
  input  eqv_algo_pkg::eqv_idx_t  i_idx,
  output logic                    o_val,
  output logic                    o_last,
  output eqv_algo_pkg::eqv_str_t  o_str
);
  import eqv_algo_pkg::*;

  eqv_seed_t              seed_q;
  logic [63:0]            stg_q [HASH_ROUNDS];
  logic [HASH_ROUNDS-1:0] val_q;
  logic [HASH_ROUNDS-1:0] last_q;

  // One add-rotate-xor round; the round number lands in the low byte
  function automatic logic [63:0] mix_round(
    input logic [63:0] w,
    input eqv_seed_t   k,
    input int unsigned r
  );
    logic [63:0] s;
    logic [63:0] t;
    s = w + k;
    t = {s[50:0], s[63:51]};
    t[7:0] = t[7:0] ^ r[7:0];
    return t;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      seed_q <= i_seed;
    end
  end

  // One register per round, so each string trails its index by HASH_ROUNDS cycles
  always_ff @(posedge i_clk) begin
    stg_q[0] <= mix_round(64'(i_idx), seed_q, 0);
    for (int r = 1; r < HASH_ROUNDS; r++) begin
      stg_q[r] <= mix_round(stg_q[r-1], seed_q, r);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q  <= '0;
      last_q <= '0;
    end else begin
      val_q[0]  <= i_val;
      last_q[0] <= i_val & i_last;
      for (int r = 1; r < HASH_ROUNDS; r++) begin
        val_q[r]  <= val_q[r-1];
        last_q[r] <= last_q[r-1];
      end
    end
  end

  assign o_val  = val_q[HASH_ROUNDS-1];
  assign o_last = last_q[HASH_ROUNDS-1];
  assign o_str  = stg_q[HASH_ROUNDS-1][63 -: EQV_N];

endmodule

/* verilog/eqv_index_rules.sv */
module eqv_index_rules (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_val,
  input  logic                   i_first,
  input  logic                   i_last,
  input  eqv_algo_pkg::eqv_idx_t i_idx,
  output logic                   o_res_val,
  output logic                   o_bad_idx_order,
  output logic                   o_dup_fnd
);
  import eqv_algo_pkg::*;

  localparam int CNT_W = $clog2(EQV_SOL_LEN);

  eqv_idx_t         idx_q [EQV_SOL_LEN];
  logic [CNT_W-1:0] wp_q;
  logic             eval_q;

  // A first index always lands in slot 0
  always_ff @(posedge i_clk) begin
    if (i_val) begin
      if (i_first) begin
        idx_q[0] <= i_idx;
      end else begin
        idx_q[wp_q] <= i_idx;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wp_q   <= '0;
      eval_q <= 1'b0;
    end else begin
      eval_q <= i_val & i_last;
      if (i_val) begin
        wp_q <= i_first ? CNT_W'(1) : wp_q + 1'b1;
      end
    end
  end

  // Checked on the cycle after last, when all slots hold the new solution
  always_comb begin
    o_bad_idx_order = 1'b0;
    o_dup_fnd       = 1'b0;
    for (int h = 1; h <= EQV_K; h++) begin
      // Left sibling starts at b*2**h, right sibling 2**(h-1) later
      for (int b = 0; b < (EQV_SOL_LEN >> h); b++) begin
        if (idx_q[b << h] >= idx_q[(b << h) + (1 << (h - 1))]) begin
          o_bad_idx_order = 1'b1;
        end
      end
    end
    for (int i = 0; i < EQV_SOL_LEN; i++) begin
      for (int j = i + 1; j < EQV_SOL_LEN; j++) begin
        if (idx_q[i] == idx_q[j]) begin
          o_dup_fnd = 1'b1;
        end
      end
    end
  end

  assign o_res_val = eval_q;

  // The unpacker must leave a gap after a solution for the checks to settle
  a_no_idx_in_eval: assert property (@(posedge i_clk) disable iff (i_rst)
    eval_q |-> !i_val);

endmodule

/* verilog/eqv_index_unpack.sv */
module eqv_index_unpack (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic                                  i_start,
  input  logic [eqv_algo_pkg::EQV_SOL_BITS-1:0] i_sol,
  output logic                                  o_val,
  output logic                                  o_first,
  output logic                                  o_last,
  output eqv_algo_pkg::eqv_idx_t                o_idx
);
  import eqv_algo_pkg::*;

  localparam int CNT_W = $clog2(EQV_SOL_LEN);

  eqv_run_e              state;
  logic [CNT_W-1:0]      cnt_q;
  logic [EQV_SOL_BITS-1:0] sh_q;

  // The solution is taken whole at start, so later bus writes cannot disturb it
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      sh_q <= i_sol;
    end else if (state == ST_RUN) begin
      sh_q <= sh_q >> EQV_IDX_BITS;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ST_IDLE;
      cnt_q <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          cnt_q <= '0;
          if (i_start) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(EQV_SOL_LEN - 1)) begin
            state <= ST_IDLE;
            cnt_q <= '0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Fields leave from the least significant end
  assign o_idx   = sh_q[EQV_IDX_BITS-1:0];
  assign o_val   = (state == ST_RUN);
  assign o_first = o_val && (cnt_q == '0);
  assign o_last  = (cnt_q == CNT_W'(EQV_SOL_LEN - 1));

  a_last_val: assert property (@(posedge i_clk) disable iff (i_rst)
    o_last |-> o_val);

endmodule

/* verilog/eqv_top.sv */
module eqv_top #(
  parameter int HASH_ROUNDS = 4
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_wb_cyc,
  input  logic                              i_wb_stb,
  input  logic                              i_wb_we,
  input  logic [eqv_bus_pkg::EQV_WB_AW-1:0] i_wb_adr,
  input  logic [eqv_bus_pkg::EQV_WB_DW-1:0] i_wb_dat,
  output logic [eqv_bus_pkg::EQV_WB_DW-1:0] o_wb_dat,
  output logic                              o_wb_ack
);
  import eqv_algo_pkg::*;

  logic                    start;
  eqv_seed_t               seed;
  logic [EQV_SOL_BITS-1:0] sol;
  logic                    idx_val;
  logic                    idx_first;
  logic                    idx_last;
  eqv_idx_t                idx;
  logic                    str_val;
  logic                    str_last;
  eqv_str_t                str;
  logic                    xor_val;
  logic                    xor_non_zero;
  logic                    bad_zero_order;
  logic                    rule_val;
  logic                    bad_idx_order;
  logic                    dup_fnd;

  eqv_wb_regs u_regs (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .i_xor_val   (xor_val),
    .i_xor_mask  ({bad_zero_order, xor_non_zero}),
    .i_rule_val  (rule_val),
    .i_rule_mask ({dup_fnd, bad_idx_order}),
    .o_start     (start),
    .o_seed      (seed),
    .o_sol       (sol)
  );

  eqv_index_unpack u_unpack (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (start),
    .i_sol   (sol),
    .o_val   (idx_val),
    .o_first (idx_first),
    .o_last  (idx_last),
    .o_idx   (idx)
  );

  eqv_index_hash #(
    .HASH_ROUNDS (HASH_ROUNDS)
  ) u_hash (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (start),
    .i_seed  (seed),
    .i_val   (idx_val),
    .i_last  (idx_last),
    .i_idx   (idx),
    .o_val   (str_val),
    .o_last  (str_last),
    .o_str   (str)
  );

  eqv_xor_check u_xor (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_val            (str_val),
    .i_last           (str_last),
    .i_str            (str),
    .o_res_val        (xor_val),
    .o_xor_non_zero   (xor_non_zero),
    .o_bad_zero_order (bad_zero_order)
  );

  eqv_index_rules u_rules (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_val           (idx_val),
    .i_first         (idx_first),
    .i_last          (idx_last),
    .i_idx           (idx),
    .o_res_val       (rule_val),
    .o_bad_idx_order (bad_idx_order),
    .o_dup_fnd       (dup_fnd)
  );

endmodule

/* verilog/eqv_wb_regs.sv */
module eqv_wb_regs (
  input  logic                                       i_clk,
  input  logic                                       i_rst,
  input  logic                                       i_wb_cyc,
  input  logic                                       i_wb_stb,
  input  logic                                       i_wb_we,
  input  logic [eqv_bus_pkg::EQV_WB_AW-1:0]          i_wb_adr,
  input  logic [eqv_bus_pkg::EQV_WB_DW-1:0]          i_wb_dat,
  output logic [eqv_bus_pkg::EQV_WB_DW-1:0]          o_wb_dat,
  output logic                                       o_wb_ack,
  input  logic                                       i_xor_val,
  input  logic [1:0]                                 i_xor_mask,
  input  logic                                       i_rule_val,
  input  logic [1:0]                                 i_rule_mask,
  output logic                                       o_start,
  output eqv_algo_pkg::eqv_seed_t                    o_seed,
  output logic [eqv_algo_pkg::EQV_SOL_BITS-1:0]      o_sol
);
  import eqv_algo_pkg::*;
  import eqv_bus_pkg::*;

  localparam int SOL_WORDS = (EQV_SOL_BITS + EQV_WB_DW - 1) / EQV_WB_DW;

  eqv_reg_e                  reg_sel;
  logic                      bus_req;
  logic                      wr_en;
  logic                      start_req;
  logic [1:0]                sol_word;
  eqv_seed_t                 seed_q;
  logic [EQV_WB_DW-1:0]      sol_q [SOL_WORDS];
  logic [SOL_WORDS*EQV_WB_DW-1:0] sol_flat;
  logic [EQV_WB_DW-1:0]      rd_word;
  eqv_run_e                  run_st;
  logic                      done_q;
  logic                      got_xor;
  logic                      got_rule;
  eqv_mask_t                 acc_mask;
  eqv_mask_t                 acc_next;
  eqv_mask_t                 mask_q;

  assign reg_sel   = eqv_reg_e'(i_wb_adr);
  assign bus_req   = i_wb_cyc & i_wb_stb & ~o_wb_ack;
  assign wr_en     = bus_req & i_wb_we;
  assign start_req = wr_en && (reg_sel == CTRL) && (run_st == ST_IDLE);
  assign sol_word  = 2'(i_wb_adr - SOL0);

  // Seed and solution words, written on the edge that raises ack
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      case (reg_sel)
        SEED_LO: seed_q[31:0] <= i_wb_dat;
        SEED_HI: seed_q[63:32] <= i_wb_dat;
        SOL0, SOL1, SOL2, SOL3: sol_q[sol_word] <= i_wb_dat;
        default: ;
      endcase
    end
  end

  always_comb begin
    for (int w = 0; w < SOL_WORDS; w++) begin
      sol_flat[w*EQV_WB_DW +: EQV_WB_DW] = sol_q[w];
    end
  end

  assign o_seed = seed_q;
  assign o_sol  = sol_flat[EQV_SOL_BITS-1:0];

  always_comb begin
    rd_word = '0;
    case (reg_sel)
      SEED_LO: rd_word = seed_q[31:0];
      SEED_HI: rd_word = seed_q[63:32];
      SOL0, SOL1, SOL2, SOL3: rd_word = sol_q[sol_word];
      STATUS: begin
        rd_word[STAT_DONE] = done_q;
        rd_word[STAT_BUSY] = (run_st == ST_RUN);
        rd_word[STAT_MASK_LSB +: $bits(eqv_mask_t)] = mask_q;
      end
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (bus_req) begin
      o_wb_dat <= rd_word;
    end
  end

  // Merge whichever stage results arrive this cycle into the pending mask
  always_comb begin
    acc_next = acc_mask;
    if (i_xor_val) begin
      acc_next[BAD_ZERO_ORDER:XOR_NON_ZERO] = i_xor_mask;
    end
    if (i_rule_val) begin
      acc_next[DUPLICATE_FND:BAD_IDX_ORDER] = i_rule_mask;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_ack <= 1'b0;
      o_start  <= 1'b0;
      run_st   <= ST_IDLE;
      done_q   <= 1'b0;
      got_xor  <= 1'b0;
      got_rule <= 1'b0;
      acc_mask <= '0;
      mask_q   <= '0;
    end else begin
      o_wb_ack <= bus_req;
      o_start  <= start_req;
      case (run_st)
        ST_IDLE: begin
          if (start_req) begin
            run_st   <= ST_RUN;
            done_q   <= 1'b0;
            got_xor  <= 1'b0;
            got_rule <= 1'b0;
            acc_mask <= '0;
            mask_q   <= '0;
          end
        end
        ST_RUN: begin
          acc_mask <= acc_next;
          got_xor  <= got_xor | i_xor_val;
          got_rule <= got_rule | i_rule_val;
          // Both checks reported, so publish the mask and drop busy together
          if ((got_xor | i_xor_val) && (got_rule | i_rule_val)) begin
            run_st <= ST_IDLE;
            done_q <= 1'b1;
            mask_q <= acc_next;
          end
        end
        default: run_st <= ST_IDLE;
      endcase
    end
  end

  a_ack_single: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_ack |=> !o_wb_ack);

endmodule

/* verilog/eqv_xor_check.sv */
module eqv_xor_check (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_val,
  input  logic                   i_last,
  input  eqv_algo_pkg::eqv_str_t i_str,
  output logic                   o_res_val,
  output logic                   o_xor_non_zero,
  output logic                   o_bad_zero_order
);
  import eqv_algo_pkg::*;

  localparam int CNT_W = $clog2(EQV_SOL_LEN);

  logic [CNT_W-1:0] cnt_q;
  eqv_str_t         acc_q [1:EQV_K];
  eqv_str_t         blk [1:EQV_K];
  logic             bad_q;
  logic             bad_now;
  logic             bad_run;

  always_comb begin
    bad_now = 1'b0;
    for (int h = 1; h <= EQV_K; h++) begin
      // A level-h block covers 2**h strings and opens on an aligned count
      if ((int'(cnt_q) % (1 << h)) == 0) begin
        blk[h] = i_str;
      end else begin
        blk[h] = acc_q[h] ^ i_str;
      end
      // On the closing string the top h slices must have cancelled
      if ((int'(cnt_q) % (1 << h)) == (1 << h) - 1) begin
        if ((blk[h] >> (EQV_N - h * EQV_COLL_BITS)) != '0) begin
          bad_now = 1'b1;
        end
      end
    end
    bad_run = (cnt_q == '0) ? bad_now : (bad_q | bad_now);
  end

  always_ff @(posedge i_clk) begin
    if (i_val) begin
      for (int h = 1; h <= EQV_K; h++) begin
        acc_q[h] <= blk[h];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt_q            <= '0;
      bad_q            <= 1'b0;
      o_res_val        <= 1'b0;
      o_xor_non_zero   <= 1'b0;
      o_bad_zero_order <= 1'b0;
    end else begin
      o_res_val <= i_val & i_last;
      if (i_val) begin
        cnt_q <= i_last ? '0 : cnt_q + 1'b1;
        bad_q <= bad_run;
        if (i_last) begin
          // The top-level block is the XOR of the whole solution
          o_xor_non_zero   <= |blk[EQV_K];
          o_bad_zero_order <= bad_run;
        end
      end
    end
  end

endmodule
